// ==== Bender.yml ====
package:
  name: cop

sources:
  - rtl/cop_cfg_pkg.sv
  - rtl/cop_types_pkg.sv
  - rtl/cop_ram.sv
  - rtl/cop_fifo.sv
  - rtl/cop_mod_mul.sv
  - rtl/cop_apb_bridge.sv
  - rtl/cop_sequencer.sv
  - rtl/cop_interrupt_tx.sv
  - rtl/cop_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/cop_tb.sv

// ==== filelist.f ====
rtl/cop_cfg_pkg.sv
rtl/cop_types_pkg.sv
rtl/cop_ram.sv
rtl/cop_fifo.sv
rtl/cop_mod_mul.sv
rtl/cop_apb_bridge.sv
rtl/cop_sequencer.sv
rtl/cop_interrupt_tx.sv
rtl/cop_top.sv
testbench/tb_clock_gen.sv
testbench/cop_tb.sv

// ==== rtl/cop_apb_bridge.sv ====
/*
  APB slave for the host. Maps the control register and both RAMs.
  RAM reads take one wait state; writes and control reads finish at once.
*/
`timescale 1ns/1ps
module cop_apb_bridge
  import cop_cfg_pkg::*;
  import cop_types_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  logic [APB_ADDR_BITS-1:0] i_paddr,
  input  logic [APB_DATA_BITS-1:0] i_pwdata,
  output logic [APB_DATA_BITS-1:0] o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,
  output logic                     o_inst_en,
  output logic                     o_inst_we,
  output logic [INST_AW-1:0]       o_inst_addr,
  output inst_t                    o_inst_wdata,
  input  inst_t                    i_inst_rdata,
  output logic                     o_data_en,
  output logic                     o_data_we,
  output logic [DATA_AW-1:0]       o_data_addr,
  output slot_t                    o_data_wdata,
  input  slot_t                    i_data_rdata,
  output logic                     o_start,
  output logic [INST_AW-1:0]       o_start_pt,
  input  logic                     i_busy,
  input  logic [INST_AW-1:0]       i_inst_pt
);

  logic                     access;
  logic                     is_ctrl;
  logic                     is_inst;
  logic                     is_data;
  logic                     is_ram;
  logic                     rd_wait;
  logic [APB_ADDR_BITS-1:0] inst_off;
  logic [APB_ADDR_BITS-1:0] data_off;

  // Address decode
  assign access   = i_psel && i_penable;
  assign inst_off = i_paddr - INST_BASE;
  assign data_off = i_paddr - DATA_BASE;
  assign is_ctrl  = (i_paddr == ADDR_CTRL);
  assign is_inst  = (i_paddr >= INST_BASE) && (inst_off < INST_DEPTH);
  assign is_data  = (i_paddr >= DATA_BASE) && (data_off < DATA_DEPTH);
  assign is_ram   = is_inst || is_data;

  assign o_pready  = access && (i_pwrite || !is_ram || rd_wait);
  assign o_pslverr = o_pready && !(is_ctrl || is_ram);

  // RAM port A, one access per APB transfer
  assign o_inst_en    = access && is_inst && !rd_wait;
  assign o_inst_we    = i_pwrite;
  assign o_inst_addr  = INST_AW'(inst_off);
  assign o_inst_wdata = inst_t'(i_pwdata);
  assign o_data_en    = access && is_data && !rd_wait;
  assign o_data_we    = i_pwrite;
  assign o_data_addr  = DATA_AW'(data_off);
  assign o_data_wdata = slot_t'(i_pwdata);

  assign o_start    = access && i_pwrite && is_ctrl;
  assign o_start_pt = i_pwdata[INST_AW-1:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) rd_wait <= 1'b0;
    else rd_wait <= access && !i_pwrite && is_ram && !rd_wait;
  end

  always_comb begin
    o_prdata = '0;
    if (rd_wait && is_inst) o_prdata = i_inst_rdata;
    else if (rd_wait && is_data) o_prdata = i_data_rdata;
    // Status word with busy above the pointer
    else if (is_ctrl && !i_pwrite)
      o_prdata = {{(APB_DATA_BITS-INST_AW-1){1'b0}}, i_busy, i_inst_pt};
  end

endmodule

// ==== rtl/cop_cfg_pkg.sv ====
/*
  Sizes, modulus and host address map of the field-arithmetic coprocessor.
  Imported by any block that needs a width, a depth or an address.
*/
package cop_cfg_pkg;

  // Field element and modulus
  localparam int DAT_BITS = 30;
  localparam logic [DAT_BITS-1:0] P = DAT_BITS'(1073741789);

  // Memory sizes
  localparam int INST_DEPTH = 256;
  localparam int DATA_DEPTH = 256;
  localparam int INST_AW = $clog2(INST_DEPTH);
  localparam int DATA_AW = $clog2(DATA_DEPTH);

  // APB host port and its address map
  localparam int APB_ADDR_BITS = 16;
  localparam int APB_DATA_BITS = 32;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_CTRL = 16'h0000;
  localparam logic [APB_ADDR_BITS-1:0] INST_BASE = 16'h1000;
  localparam logic [APB_ADDR_BITS-1:0] DATA_BASE = 16'h2000;

  // Interrupt path buffering
  localparam int IDX_FIFO_DEPTH = 4;
  localparam int DAT_FIFO_DEPTH = 8;

endpackage

// ==== rtl/cop_fifo.sv ====
/*
  Synchronous FIFO with valid/ready on both sides.
  Entry type and depth are parameters. The head entry is shown directly.
*/
`timescale 1ns/1ps
module cop_fifo #(
  parameter type T_ENTRY = logic [31:0],
  parameter int  DEPTH   = 4
) (
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_valid,
  output logic   o_ready,
  input  T_ENTRY i_data,
  output logic   o_valid,
  input  logic   i_ready,
  output T_ENTRY o_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T_ENTRY mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic push;
  logic pop;

  assign o_ready = (count != DEPTH);
  assign o_valid = (count != 0);
  assign o_data  = mem[rd_ptr];
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) mem[wr_ptr] <= i_data;
  end

  // A full FIFO keeps its head entry until it is popped
  a_full_no_write: assert property (@(posedge i_clk) disable iff (i_rst)
    (count == DEPTH && !i_ready) |=> $stable(o_data));
  a_count_max: assert property (@(posedge i_clk) disable iff (i_rst) count <= DEPTH);

endmodule

// ==== rtl/cop_interrupt_tx.sv ====
/*
  Interrupt path. Buffers index entries and slot words in two FIFOs and
  frames them as a header beat followed by the slot words on the tx stream.
*/
`timescale 1ns/1ps
module cop_interrupt_tx
  import cop_cfg_pkg::*;
  import cop_types_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_idx_valid,
  output logic     o_idx_ready,
  input  idx_t     i_idx,
  input  logic     i_dat_valid,
  output logic     o_dat_ready,
  input  slot_t    i_dat,
  output logic     o_tx_valid,
  input  logic     i_tx_ready,
  output tx_beat_t o_tx
);

  idx_t       idx_q;
  slot_t      dat_q;
  logic       idx_v;
  logic       idx_rdy;
  logic       dat_v;
  logic       dat_rdy;
  logic       load_ok;
  logic [7:0] left;
  enum logic {F_HDR, F_DATA} fstate;

  cop_fifo #(.T_ENTRY(idx_t), .DEPTH(IDX_FIFO_DEPTH)) idx_fifo_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_idx_valid),
    .o_ready (o_idx_ready),
    .i_data  (i_idx),
    .o_valid (idx_v),
    .i_ready (idx_rdy),
    .o_data  (idx_q)
  );

  cop_fifo #(.T_ENTRY(slot_t), .DEPTH(DAT_FIFO_DEPTH)) dat_fifo_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_dat_valid),
    .o_ready (o_dat_ready),
    .i_data  (i_dat),
    .o_valid (dat_v),
    .i_ready (dat_rdy),
    .o_data  (dat_q)
  );

  // Output register free this cycle
  assign load_ok = !o_tx_valid || i_tx_ready;
  assign idx_rdy = (fstate == F_HDR) && load_ok;
  assign dat_rdy = (fstate == F_DATA) && load_ok;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tx_valid <= 1'b0;
      fstate     <= F_HDR;
    end else begin
      if (i_tx_ready) o_tx_valid <= 1'b0;
      if (idx_v && idx_rdy) begin
        o_tx_valid <= 1'b1;
        fstate     <= F_DATA;
      end else if (dat_v && dat_rdy) begin
        o_tx_valid <= 1'b1;
        if (left == 8'd1) fstate <= F_HDR;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (idx_v && idx_rdy) begin
      o_tx <= '{sop: 1'b1, eop: 1'b0, dat: {{(32-$bits(idx_t)){1'b0}}, idx_q}};
      left <= idx_q.len;
    end else if (dat_v && dat_rdy) begin
      o_tx <= '{sop: 1'b0, eop: (left == 8'd1), dat: dat_q};
      left <= left - 1'b1;
    end
  end

  a_tx_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_tx_valid && !i_tx_ready) |=> o_tx_valid && $stable(o_tx));

endmodule

// ==== rtl/cop_mod_mul.sv ====
/*
  Bit-serial modular multiplier, one operand bit per cycle, MSB first.
  Takes DAT_BITS+1 cycles from the input transfer to a valid product.
*/
`timescale 1ns/1ps
module cop_mod_mul
  import cop_cfg_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  output logic                o_ready,
  input  logic [DAT_BITS-1:0] i_a,
  input  logic [DAT_BITS-1:0] i_b,
  output logic                o_valid,
  input  logic                i_ready,
  output logic [DAT_BITS-1:0] o_prod
);

  localparam int CNT_W = $clog2(DAT_BITS);

  logic                running;
  logic [CNT_W-1:0]    cnt;
  logic [DAT_BITS-1:0] acc;
  logic [DAT_BITS-1:0] a_sh;
  logic [DAT_BITS-1:0] b_l;
  logic [DAT_BITS:0]   dbl;
  logic [DAT_BITS:0]   dbl_r;
  logic [DAT_BITS:0]   sum;
  logic [DAT_BITS:0]   sum_r;

  // Only one product in flight
  assign o_ready = !running && !o_valid;
  assign o_prod  = acc;

  // acc = 2*acc + bit*b with a reduction after each add
  always_comb begin
    dbl   = {acc, 1'b0};
    dbl_r = (dbl >= P) ? dbl - P : dbl;
    sum   = dbl_r + (a_sh[DAT_BITS-1] ? {1'b0, b_l} : '0);
    sum_r = (sum >= P) ? sum - P : sum;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      running <= 1'b0;
      o_valid <= 1'b0;
      cnt     <= '0;
    end else begin
      if (o_valid && i_ready) o_valid <= 1'b0;
      if (i_valid && o_ready) begin
        running <= 1'b1;
        cnt     <= '0;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        // Result goes out with the last bit
        if (cnt == CNT_W'(DAT_BITS-1)) begin
          running <= 1'b0;
          o_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      acc  <= '0;
      a_sh <= i_a;
      b_l  <= i_b;
    end else if (running) begin
      acc  <= sum_r[DAT_BITS-1:0];
      a_sh <= a_sh << 1;
    end
  end

  // Reduction only works on operands already in the field
  a_operands_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_valid && o_ready) |-> (i_a < P) && (i_b < P));

endmodule

// ==== rtl/cop_ram.sv ====
/*
  True dual-port RAM with registered reads on both ports.
  The word type is a parameter, so one module holds instructions or slots.
*/
`timescale 1ns/1ps
module cop_ram #(
  parameter type T_WORD = logic [31:0],
  parameter int  DEPTH  = 256
) (
  input  logic                     i_clk,
  input  logic                     i_a_en,
  input  logic                     i_a_we,
  input  logic [$clog2(DEPTH)-1:0] i_a_addr,
  input  T_WORD                    i_a_wdata,
  output T_WORD                    o_a_rdata,
  input  logic                     i_b_en,
  input  logic                     i_b_we,
  input  logic [$clog2(DEPTH)-1:0] i_b_addr,
  input  T_WORD                    i_b_wdata,
  output T_WORD                    o_b_rdata
);

  T_WORD mem [DEPTH];

  // Read-first on each port; output holds while the port is idle
  always_ff @(posedge i_clk) begin
    if (i_a_en) begin
      if (i_a_we) mem[i_a_addr] <= i_a_wdata;
      o_a_rdata <= mem[i_a_addr];
    end
    if (i_b_en) begin
      if (i_b_we) mem[i_b_addr] <= i_b_wdata;
      o_b_rdata <= mem[i_b_addr];
    end
  end

endmodule

// ==== rtl/cop_sequencer.sv ====
/*
  Instruction sequencer. Fetches from the start pointer and runs
  COPY_REG, MUL_ELEMENT and SEND_INTERRUPT until it meets NOOP_WAIT.
*/
`timescale 1ns/1ps
module cop_sequencer
  import cop_cfg_pkg::*;
  import cop_types_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic [INST_AW-1:0]  i_start_pt,
  output logic                o_busy,
  output logic [INST_AW-1:0]  o_inst_pt,
  output logic [INST_AW-1:0]  o_inst_addr,
  input  inst_t               i_inst,
  output logic                o_slot_en,
  output logic                o_slot_we,
  output logic [DATA_AW-1:0]  o_slot_addr,
  output slot_t               o_slot_wdata,
  input  slot_t               i_slot,
  output logic                o_mul_valid,
  input  logic                i_mul_ready,
  output logic [DAT_BITS-1:0] o_mul_a,
  output logic [DAT_BITS-1:0] o_mul_b,
  input  logic                i_mul_valid,
  input  logic [DAT_BITS-1:0] i_mul_prod,
  output logic                o_idx_valid,
  input  logic                i_idx_ready,
  output idx_t                o_idx,
  output logic                o_irq_valid,
  input  logic                i_irq_ready,
  output slot_t               o_irq
);

  typedef enum logic [3:0] {
    S_IDLE, S_FETCH, S_DECODE, S_COPY, S_RD_B, S_MUL, S_WAIT, S_IDX, S_SRD, S_SPUSH
  } state_t;

  state_t              state;
  logic [INST_AW-1:0]  pt;
  inst_t               inst;
  logic [DAT_BITS-1:0] opa;
  logic [7:0]          left;
  logic [DATA_AW-1:0]  saddr;

  assign o_busy      = (state != S_IDLE);
  assign o_inst_pt   = pt;
  assign o_inst_addr = pt;

  // Slot RAM output holds while port B is idle, so operands come straight from it
  assign o_mul_valid = (state == S_MUL);
  assign o_mul_a     = opa;
  assign o_mul_b     = i_slot.dat;
  assign o_idx_valid = (state == S_IDX);
  assign o_idx       = '{pt: i_slot.pt, id: inst.b, len: pt_words(i_slot.pt)};
  assign o_irq_valid = (state == S_SPUSH);
  assign o_irq       = i_slot;

  always_comb begin
    o_slot_en    = 1'b1;
    o_slot_we    = 1'b0;
    o_slot_addr  = saddr;
    o_slot_wdata = i_slot;
    case (state)
      // Slot a is read while the instruction is decoded
      S_DECODE: o_slot_addr = DATA_AW'(i_inst.a);
      S_COPY: begin
        o_slot_we   = 1'b1;
        o_slot_addr = DATA_AW'(inst.b);
      end
      S_RD_B: o_slot_addr = DATA_AW'(inst.b);
      S_WAIT: begin
        o_slot_en    = i_mul_valid;
        o_slot_we    = 1'b1;
        o_slot_addr  = DATA_AW'(inst.c);
        o_slot_wdata = '{pt: FE, dat: i_mul_prod};
      end
      S_SRD: o_slot_addr = saddr;
      default: o_slot_en = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= S_IDLE;
      pt    <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_start) begin
            pt    <= i_start_pt;
            state <= S_FETCH;
          end
        end
        S_FETCH: state <= S_DECODE;
        S_DECODE: begin
          case (i_inst.code)
            COPY_REG:       state <= S_COPY;
            MUL_ELEMENT:    state <= S_RD_B;
            SEND_INTERRUPT: state <= S_IDX;
            // Pointer stays on the NOOP_WAIT
            default:        state <= S_IDLE;
          endcase
        end
        S_COPY: begin
          pt    <= pt + 1'b1;
          state <= S_FETCH;
        end
        S_RD_B: state <= S_MUL;
        S_MUL: if (i_mul_ready) state <= S_WAIT;
        S_WAIT: begin
          if (i_mul_valid) begin
            pt    <= pt + 1'b1;
            state <= S_FETCH;
          end
        end
        S_IDX: if (i_idx_ready) state <= S_SRD;
        S_SRD: state <= S_SPUSH;
        S_SPUSH: begin
          if (i_irq_ready) begin
            if (left == 8'd1) begin
              pt    <= pt + 1'b1;
              state <= S_FETCH;
            end else begin
              state <= S_SRD;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_DECODE) inst <= i_inst;
    if (state == S_RD_B) opa <= i_slot.dat;
    if (state == S_IDX) begin
      left  <= pt_words(i_slot.pt);
      saddr <= DATA_AW'(inst.a);
    end
    if (state == S_SPUSH && i_irq_ready) begin
      left  <= left - 1'b1;
      saddr <= saddr + 1'b1;
    end
  end

endmodule

// ==== rtl/cop_top.sv ====
/*
  Coprocessor top level. The host loads programs and slots over APB and
  starts the sequencer; SEND_INTERRUPT results leave on the tx stream.
*/
`timescale 1ns/1ps
module cop_top
  import cop_cfg_pkg::*;
  import cop_types_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  logic [APB_ADDR_BITS-1:0] i_paddr,
  input  logic [APB_DATA_BITS-1:0] i_pwdata,
  output logic [APB_DATA_BITS-1:0] o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,
  output logic                     o_tx_valid,
  input  logic                     i_tx_ready,
  output tx_beat_t                 o_tx
);

  // Host side of the RAMs
  logic inst_en_a, inst_we_a, data_en_a, data_we_a;
  logic [INST_AW-1:0] inst_addr_a;
  logic [DATA_AW-1:0] data_addr_a;
  inst_t inst_wdata_a, inst_rdata_a;
  slot_t data_wdata_a, data_rdata_a;

  // Sequencer side
  logic [INST_AW-1:0] inst_addr_b, start_pt, inst_pt;
  inst_t inst_rdata_b;
  logic slot_en_b, slot_we_b, start, busy;
  logic [DATA_AW-1:0] slot_addr_b;
  slot_t slot_wdata_b, slot_rdata_b;

  logic mul_valid, mul_ready, prod_valid;
  logic [DAT_BITS-1:0] mul_a, mul_b, prod;
  logic idx_valid, idx_ready, irq_valid, irq_ready;
  idx_t idx;
  slot_t irq;

  cop_ram #(.T_WORD(inst_t), .DEPTH(INST_DEPTH)) inst_ram_i (
    .i_clk(i_clk),
    .i_a_en(inst_en_a), .i_a_we(inst_we_a), .i_a_addr(inst_addr_a),
    .i_a_wdata(inst_wdata_a), .o_a_rdata(inst_rdata_a),
    .i_b_en(1'b1), .i_b_we(1'b0), .i_b_addr(inst_addr_b),
    .i_b_wdata('0), .o_b_rdata(inst_rdata_b)
  );

  cop_ram #(.T_WORD(slot_t), .DEPTH(DATA_DEPTH)) slot_ram_i (
    .i_clk(i_clk),
    .i_a_en(data_en_a), .i_a_we(data_we_a), .i_a_addr(data_addr_a),
    .i_a_wdata(data_wdata_a), .o_a_rdata(data_rdata_a),
    .i_b_en(slot_en_b), .i_b_we(slot_we_b), .i_b_addr(slot_addr_b),
    .i_b_wdata(slot_wdata_b), .o_b_rdata(slot_rdata_b)
  );

  cop_apb_bridge bridge_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_prdata(o_prdata),
    .o_pready(o_pready), .o_pslverr(o_pslverr),
    .o_inst_en(inst_en_a), .o_inst_we(inst_we_a), .o_inst_addr(inst_addr_a),
    .o_inst_wdata(inst_wdata_a), .i_inst_rdata(inst_rdata_a),
    .o_data_en(data_en_a), .o_data_we(data_we_a), .o_data_addr(data_addr_a),
    .o_data_wdata(data_wdata_a), .i_data_rdata(data_rdata_a),
    .o_start(start), .o_start_pt(start_pt), .i_busy(busy), .i_inst_pt(inst_pt)
  );

  cop_sequencer seq_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_start(start), .i_start_pt(start_pt), .o_busy(busy), .o_inst_pt(inst_pt),
    .o_inst_addr(inst_addr_b), .i_inst(inst_rdata_b),
    .o_slot_en(slot_en_b), .o_slot_we(slot_we_b), .o_slot_addr(slot_addr_b),
    .o_slot_wdata(slot_wdata_b), .i_slot(slot_rdata_b),
    .o_mul_valid(mul_valid), .i_mul_ready(mul_ready), .o_mul_a(mul_a), .o_mul_b(mul_b),
    .i_mul_valid(prod_valid), .i_mul_prod(prod),
    .o_idx_valid(idx_valid), .i_idx_ready(idx_ready), .o_idx(idx),
    .o_irq_valid(irq_valid), .i_irq_ready(irq_ready), .o_irq(irq)
  );

  // Single client takes the product as soon as it is valid
  cop_mod_mul mul_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_valid(mul_valid), .o_ready(mul_ready), .i_a(mul_a), .i_b(mul_b),
    .o_valid(prod_valid), .i_ready(1'b1), .o_prod(prod)
  );

  cop_interrupt_tx irq_tx_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_idx_valid(idx_valid), .o_idx_ready(idx_ready), .i_idx(idx),
    .i_dat_valid(irq_valid), .o_dat_ready(irq_ready), .i_dat(irq),
    .o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready), .o_tx(o_tx)
  );

endmodule

// ==== rtl/cop_types_pkg.sv ====
/*
  Instruction, slot and stream types shared by the coprocessor blocks.
  Also holds the words-per-point-type rule used when sending interrupts.
*/
package cop_types_pkg;
  import cop_cfg_pkg::*;

  // Unknown codes behave as NOOP_WAIT
  typedef enum logic [7:0] {
    NOOP_WAIT      = 8'd0,
    COPY_REG       = 8'd1,
    MUL_ELEMENT    = 8'd2,
    SEND_INTERRUPT = 8'd3
  } code_t;

  typedef struct packed {
    code_t      code;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
  } inst_t;

  typedef enum logic [1:0] {
    FE    = 2'd0,
    FE2   = 2'd1,
    FP_AF = 2'd2,
    FP_JB = 2'd3
  } point_type_t;

  // Tag and element share one slot word
  typedef struct packed {
    point_type_t         pt;
    logic [DAT_BITS-1:0] dat;
  } slot_t;

  typedef struct packed {
    point_type_t pt;
    logic [7:0]  id;
    logic [7:0]  len;
  } idx_t;

  typedef struct packed {
    logic        sop;
    logic        eop;
    logic [31:0] dat;
  } tx_beat_t;

  function automatic logic [7:0] pt_words(point_type_t pt);
    case (pt)
      FE:      return 8'd1;
      FP_JB:   return 8'd3;
      default: return 8'd2;
    endcase
  endfunction

endpackage

// ==== testbench/cop_tb.sv ====
/*
  Testbench for the coprocessor top level. Loads RAMs over APB, runs
  COPY_REG, MUL_ELEMENT and SEND_INTERRUPT programs with random operands
  and compares slots, status and tx packets against a model of the rules.
*/
`timescale 1ns/1ps
module cop_tb
  import cop_cfg_pkg::*;
  import cop_types_pkg::*;
();

  localparam logic [31:0] SEED = 32'h83394e4e;
  localparam int SAMPLE_DELAY = 10;
  localparam int N_COPY = 6;
  localparam int N_MUL  = 6;
  localparam int N_IRQ  = 8;
  localparam int N_INSTR = N_COPY + N_MUL + N_IRQ + 3;
  localparam int WATCHDOG_CYCLES = 200 * N_INSTR + 2000;
  localparam logic [7:0] COPY_BASE = 8'h10;
  localparam logic [7:0] MUL_BASE  = 8'h40;
  localparam logic [7:0] IRQ_BASE  = 8'h80;

  logic clk;
  logic rst;
  logic psel;
  logic penable;
  logic pwrite;
  logic [APB_ADDR_BITS-1:0] paddr;
  logic [APB_DATA_BITS-1:0] pwdata;
  logic [APB_DATA_BITS-1:0] prdata;
  logic pready;
  logic pslverr;
  logic tx_valid;
  logic tx_ready;
  tx_beat_t tx;

  // Model state
  logic [31:0] inst_m [256];
  logic [31:0] slot_m [256];
  logic [33:0] exp_beats [$];
  logic [31:0] rng_state;
  logic [31:0] tx_rng;
  int checks;
  int errors;

  tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) clk_gen_i (
    .o_clk (clk),
    .o_rst (rst)
  );

  cop_top dut_i (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr),
    .o_tx_valid (tx_valid),
    .i_tx_ready (tx_ready),
    .o_tx       (tx)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  // Built from upper halves since the low LCG bits repeat quickly
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic logic [31:0] rand_below(input logic [31:0] n);
    return rand_word() % n;
  endfunction

  function automatic logic [7:0] words_for_type(input logic [1:0] pt);
    case (pt)
      2'd0: return 8'd1;
      2'd3: return 8'd3;
      default: return 8'd2;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [15:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    int exp_waits;
    logic ram_addr;
    waits = 0;
    // RAM reads take one wait state, everything else none
    ram_addr = ((addr >= INST_BASE) && (addr < INST_BASE + 16'(INST_DEPTH))) ||
               ((addr >= DATA_BASE) && (addr < DATA_BASE + 16'(DATA_DEPTH)));
    exp_waits = (!wr && ram_addr) ? 1 : 0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #(SAMPLE_DELAY);
    while (!pready && waits < 8) begin
      @(negedge clk);
      #(SAMPLE_DELAY);
      waits++;
    end
    if (!pready) begin
      errors++;
      $display("APB transfer to address %h never got PREADY", addr);
    end else begin
      check_value("apb wait states", 64'(exp_waits), 64'(waits));
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic err;
    apb_transfer(1'b1, addr, data, rdata, err);
    check_value("apb write error flag", 64'd0, 64'(err));
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, 32'd0, data, err);
    check_value("apb read error flag", 64'd0, 64'(err));
  endtask

  task automatic load_slot(input logic [7:0] idx, input logic [31:0] word);
    apb_write(DATA_BASE + 16'(idx), word);
    slot_m[idx] = word;
  endtask

  task automatic load_inst(input logic [7:0] idx, input logic [31:0] word);
    apb_write(INST_BASE + 16'(idx), word);
    inst_m[idx] = word;
  endtask

  task automatic wait_idle(output logic [31:0] status);
    int polls;
    polls = 0;
    apb_read(ADDR_CTRL, status);
    while (status[8] && polls < 400) begin
      apb_read(ADDR_CTRL, status);
      polls++;
    end
    if (status[8]) begin
      errors++;
      $display("Sequencer still busy after %0d status reads", polls);
    end
  endtask

  // Ends the program with NOOP_WAIT, starts it and checks the final status
  task automatic run_program(input logic [7:0] base, input int n);
    logic [31:0] status;
    logic [7:0] stop;
    stop = 8'(base + n);
    load_inst(stop, 32'd0);
    apb_write(ADDR_CTRL, 32'(base));
    wait_idle(status);
    check_value("program end status", 64'({1'b0, stop}), 64'(status[8:0]));
  endtask

  task automatic test_apb_access();
    logic [7:0] addrs [8];
    logic [31:0] rdata;
    logic err;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 8'(rand_below(256));
      load_inst(addrs[i], rand_word());
      load_slot(addrs[i] ^ 8'h5a, rand_word());
    end
    for (int i = 0; i < 8; i++) begin
      apb_read(INST_BASE + 16'(addrs[i]), rdata);
      check_value("inst readback", 64'(inst_m[addrs[i]]), 64'(rdata));
      apb_read(DATA_BASE + 16'(addrs[i] ^ 8'h5a), rdata);
      check_value("slot readback", 64'(slot_m[addrs[i] ^ 8'h5a]), 64'(rdata));
    end
    apb_transfer(1'b0, 16'h3000, 32'd0, rdata, err);
    check_value("unmapped read error flag", 64'd1, 64'(err));
    check_value("unmapped read data", 64'd0, 64'(rdata));
    apb_transfer(1'b1, 16'h1100, rand_word(), rdata, err);
    check_value("unmapped write error flag", 64'd1, 64'(err));
    apb_transfer(1'b0, ADDR_CTRL, 32'd0, rdata, err);
    check_value("control read error flag", 64'd0, 64'(err));
    check_value("idle busy flag", 64'd0, 64'(rdata[8]));
  endtask

  task automatic test_copy();
    logic [7:0] src [N_COPY];
    logic [7:0] dst [N_COPY];
    logic [31:0] rdata;
    for (int i = 0; i < N_COPY; i++) begin
      src[i] = 8'(rand_below(64));
      dst[i] = 8'(64 + rand_below(64));
      load_slot(src[i], rand_word());
    end
    for (int i = 0; i < N_COPY; i++) begin
      load_inst(8'(COPY_BASE + i), {8'd1, src[i], dst[i], 8'(rand_word())});
      slot_m[dst[i]] = slot_m[src[i]];
    end
    run_program(COPY_BASE, N_COPY);
    for (int i = 0; i < N_COPY; i++) begin
      apb_read(DATA_BASE + 16'(dst[i]), rdata);
      check_value("copied slot", 64'(slot_m[dst[i]]), 64'(rdata));
    end
  endtask

  task automatic test_mul();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [29:0] x;
    logic [29:0] y;
    logic [63:0] prod;
    logic [31:0] rdata;
    for (int i = 0; i < N_MUL; i++) begin
      a = 8'(192 + 3 * i);
      b = 8'(a + 1);
      c = 8'(a + 2);
      // First pair at the top of the field
      x = (i == 0) ? 30'(P - 1) : 30'(rand_below(32'(P)));
      y = (i == 0) ? 30'(P - 1) : 30'(rand_below(32'(P)));
      load_slot(a, {2'(rand_word()), x});
      load_slot(b, {2'(rand_word()), y});
      load_inst(8'(MUL_BASE + i), {8'd2, a, b, c});
      prod = (64'(x) * 64'(y)) % 64'(P);
      slot_m[c] = {2'd0, prod[29:0]};
    end
    run_program(MUL_BASE, N_MUL);
    for (int i = 0; i < N_MUL; i++) begin
      c = 8'(194 + 3 * i);
      apb_read(DATA_BASE + 16'(c), rdata);
      check_value("product slot", 64'(slot_m[c]), 64'(rdata));
    end
  endtask

  task automatic test_interrupt();
    logic [7:0] a;
    logic [7:0] id;
    logic [7:0] n;
    logic [1:0] pt;
    logic [31:0] word;
    int waited;
    for (int i = 0; i < N_IRQ; i++) begin
      a  = 8'(128 + 4 * i);
      pt = 2'(i % 4);
      word = rand_word();
      load_slot(a, {pt, word[29:0]});
      load_slot(8'(a + 1), rand_word());
      load_slot(8'(a + 2), rand_word());
      id = 8'(rand_word());
      load_inst(8'(IRQ_BASE + i), {8'd3, a, id, 8'(rand_word())});
      n = words_for_type(slot_m[a][31:30]);
      exp_beats.push_back({1'b1, 1'b0, 14'd0, slot_m[a][31:30], id, n});
      for (int k = 0; k < n; k++) begin
        exp_beats.push_back({1'b0, (k == n - 1), slot_m[8'(a + k)]});
      end
    end
    run_program(IRQ_BASE, N_IRQ);
    waited = 0;
    while (exp_beats.size() != 0 && waited < 500) begin
      @(negedge clk);
      waited++;
    end
    if (exp_beats.size() != 0) begin
      errors++;
      $display("tx stream stopped with %0d beats still expected", exp_beats.size());
    end
  endtask

  // tx sink with random back-pressure; the beat is taken at the next rising edge
  initial begin
    tx_ready = 1'b0;
    tx_rng   = lcg_next(SEED);
    forever begin
      @(negedge clk);
      tx_rng   = lcg_next(tx_rng);
      tx_ready = (tx_rng[17:16] != 2'b00);
      #(SAMPLE_DELAY);
      if (tx_valid && tx_ready) begin
        if (exp_beats.size() == 0) begin
          errors++;
          $display("tx beat %h arrived when no beat was expected", tx);
        end else begin
          check_value("tx beat", 64'(exp_beats.pop_front()), 64'(tx));
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    rng_state = SEED;
    checks    = 0;
    errors    = 0;
    wait (!rst);
    test_apb_access();
    test_copy();
    test_mul();
    test_interrupt();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
  Clock and reset source for the coprocessor testbench.
  Free-running clock; synchronous reset held for a few cycles after start.
*/
`timescale 1ns/1ps
module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset drops on a rising edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule
